/* Bender.yml */
package:
  name: pid_lock

sources:
  - src/dsp_pkg.sv
  - src/ctrl_pkg.sv
  - src/oversample_filter.sv
  - src/frontpanel_regs.sv
  - src/pid_core.sv
  - src/output_mux.sv
  - src/pid_lock_top.sv
  - target: test
    files:
      - tests/pid_lock_assertions.sv
      - tests/pid_lock_tb.sv

/* src/ctrl_pkg.sv */
package ctrl_pkg;

	////////////////////////////////////////
	// host register map
	////////////////////////////////////////

	typedef enum logic [2:0] {
		REG_SETPOINT = 3'd0,  // staged setpoint
		REG_P_COEF   = 3'd1,  // staged proportional coef
		REG_I_COEF   = 3'd2,  // staged integral coef
		REG_D_COEF   = 3'd3,  // staged derivative coef
		REG_CONTROL  = 3'd4,  // lock / update_en / source bits
		REG_MANUAL   = 3'd5,  // manual output value
		CMD_UPDATE   = 3'd6,  // one cycle update pulse
		CMD_CLEAR    = 3'd7   // one cycle history clear pulse
	} reg_addr_e;

	// bit positions inside REG_CONTROL data
	localparam int unsigned CTRL_LOCK_BIT      = 0;
	localparam int unsigned CTRL_UPDATE_EN_BIT = 1;
	localparam int unsigned CTRL_SOURCE_BIT    = 2;

	////////////////////////////////////////
	// state and source encodings
	////////////////////////////////////////

	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,  // wait for valid data
		ST_COMPUTE = 2'd1,  // filter math settles
		ST_SEND    = 2'd2,  // output valid downstream
		ST_DONE    = 2'd3   // shift history
	} pid_state_e;

	typedef enum logic {
		SRC_PID    = 1'b0,  // dac follows pid
		SRC_MANUAL = 1'b1   // dac follows manual register
	} source_e;

endpackage

/* src/dsp_pkg.sv */
package dsp_pkg;

	////////////////////////////////////////
	// datapath widths
	////////////////////////////////////////

	localparam int unsigned ADC_W    = 16;    // adc sample width
	localparam int unsigned OS_COUNT = 4;     // samples per oversample sum
	localparam int unsigned W_IN     = 18;    // filter sum width
	localparam int unsigned W_OUT    = 32;    // pid internal and output width
	localparam int unsigned COEF_W   = 16;    // setpoint and coefficient width
	localparam int unsigned DAC_W    = 16;    // dac word width

	////////////////////////////////////////
	// timing and limits
	////////////////////////////////////////

	localparam int unsigned COMP_LATENCY = 1; // cycles in compute state

	// saturation limits, held at pid width so the compare is signed 32 bit
	localparam logic signed [W_OUT-1:0] DAC_MAX = 32767;   // largest dac code
	localparam logic signed [W_OUT-1:0] DAC_MIN = -32768;  // smallest dac code

endpackage

/* src/frontpanel_regs.sv */
`timescale 1ns/1ps

module frontpanel_regs (
	input  logic                               clk_in,
	input  logic                               reset_in,
	input  logic                               wr_en,         // host write strobe
	input  ctrl_pkg::reg_addr_e                wr_addr,       // register opcode
	input  logic        [dsp_pkg::COEF_W-1:0]  wr_data,       // write payload
	output logic signed [dsp_pkg::COEF_W-1:0]  setpoint,      // staged setpoint
	output logic signed [dsp_pkg::COEF_W-1:0]  p_coef,        // staged p
	output logic signed [dsp_pkg::COEF_W-1:0]  i_coef,        // staged i
	output logic signed [dsp_pkg::COEF_W-1:0]  d_coef,        // staged d
	output logic signed [dsp_pkg::COEF_W-1:0]  manual_value,  // manual dac value
	output logic                               lock_en,       // level
	output logic                               update_en,     // level
	output logic                               update,        // one cycle pulse
	output logic                               clear,         // one cycle pulse
	output ctrl_pkg::source_e                  source         // dac source select
);

	////////////////////////////////////////
	// write decode
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			setpoint     <= '0;
			p_coef       <= '0;
			i_coef       <= '0;
			d_coef       <= '0;
			manual_value <= '0;
			lock_en      <= 1'b0;
			update_en    <= 1'b0;
			source       <= ctrl_pkg::SRC_PID;
			update       <= 1'b0;
			clear        <= 1'b0;
		end else begin
			update <= 1'b0;  // command pulses drop after one cycle
			clear  <= 1'b0;
			if (wr_en) begin
				case (wr_addr)
					ctrl_pkg::REG_SETPOINT: setpoint     <= wr_data;
					ctrl_pkg::REG_P_COEF:   p_coef       <= wr_data;
					ctrl_pkg::REG_I_COEF:   i_coef       <= wr_data;
					ctrl_pkg::REG_D_COEF:   d_coef       <= wr_data;
					ctrl_pkg::REG_MANUAL:   manual_value <= wr_data;
					ctrl_pkg::REG_CONTROL: begin
						lock_en   <= wr_data[ctrl_pkg::CTRL_LOCK_BIT];
						update_en <= wr_data[ctrl_pkg::CTRL_UPDATE_EN_BIT];
						source    <= ctrl_pkg::source_e'(wr_data[ctrl_pkg::CTRL_SOURCE_BIT]);
					end
					ctrl_pkg::CMD_UPDATE:   update <= 1'b1;  // data ignored
					ctrl_pkg::CMD_CLEAR:    clear  <= 1'b1;  // data ignored
					default: ;
				endcase
			end
		end
	end

endmodule

/* src/output_mux.sv */
`timescale 1ns/1ps

module output_mux (
	input  logic                               clk_in,
	input  logic                               reset_in,
	input  logic signed [dsp_pkg::W_OUT-1:0]   pid_data,      // pid control value
	input  logic                               pid_valid,     // pid output strobe
	input  ctrl_pkg::source_e                  source,        // pid or manual
	input  logic signed [dsp_pkg::COEF_W-1:0]  manual_value,  // manual dac word
	output logic signed [dsp_pkg::DAC_W-1:0]   dac_data,      // registered dac word
	output logic                               dac_valid      // one cycle after pid_valid
);

	////////////////////////////////////////
	// saturation
	////////////////////////////////////////

	logic signed [dsp_pkg::DAC_W-1:0] pid_clamped;  // pid value in dac range

	always_comb begin
		if (pid_data > dsp_pkg::DAC_MAX) begin
			pid_clamped = dsp_pkg::DAC_MAX[dsp_pkg::DAC_W-1:0];  // 7fff
		end else if (pid_data < dsp_pkg::DAC_MIN) begin
			pid_clamped = dsp_pkg::DAC_MIN[dsp_pkg::DAC_W-1:0];  // 8000
		end else begin
			pid_clamped = pid_data[dsp_pkg::DAC_W-1:0];          // fits already
		end
	end

	////////////////////////////////////////
	// source select and output register
	////////////////////////////////////////

	// pid keeps running in manual mode, only the word is swapped
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			dac_data  <= '0;
			dac_valid <= 1'b0;
		end else begin
			dac_valid <= pid_valid;
			if (pid_valid) begin
				if (source == ctrl_pkg::SRC_MANUAL) begin
					dac_data <= manual_value;
				end else begin
					dac_data <= pid_clamped;
				end
			end
		end
	end

endmodule

/* src/oversample_filter.sv */
`timescale 1ns/1ps

module oversample_filter (
	input  logic                              clk_in,
	input  logic                              reset_in,
	input  logic signed [dsp_pkg::ADC_W-1:0]  adc_data,   // raw adc sample
	input  logic                              adc_valid,  // sample strobe
	output logic signed [dsp_pkg::W_IN-1:0]   sum_data,   // sum of four samples
	output logic                              sum_valid   // one cycle per group
);

	localparam int unsigned CNT_W = $clog2(dsp_pkg::OS_COUNT);  // 2 bits for four samples

	////////////////////////////////////////
	// accumulator state
	////////////////////////////////////////

	logic signed [dsp_pkg::W_IN-1:0] acc;         // running partial sum
	logic        [CNT_W-1:0]         sample_cnt;  // samples taken in this group
	logic signed [dsp_pkg::W_IN-1:0] acc_next;    // partial sum plus new sample
	logic                            last_sample; // group closes on this sample

	assign acc_next    = acc + adc_data;  // adc_data sign extends to W_IN
	assign last_sample = (sample_cnt == CNT_W'(dsp_pkg::OS_COUNT - 1));

	////////////////////////////////////////
	// group counting and output
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			acc        <= '0;
			sample_cnt <= '0;
			sum_data   <= '0;
			sum_valid  <= 1'b0;
		end else begin
			sum_valid <= 1'b0;  // pulse by default low
			if (adc_valid) begin
				if (last_sample) begin
					sum_data   <= acc_next;   // full group sum
					sum_valid  <= 1'b1;
					acc        <= '0;         // restart for next group
					sample_cnt <= '0;
				end else begin
					acc        <= acc_next;
					sample_cnt <= sample_cnt + 1'b1;
				end
			end
		end
	end

endmodule

/* src/pid_core.sv */
`timescale 1ns/1ps

module pid_core (
	input  logic                               clk_in,
	input  logic                               reset_in,
	input  logic signed [dsp_pkg::W_IN-1:0]    data_in,         // oversampled input
	input  logic                               data_valid_in,   // input strobe
	input  logic signed [dsp_pkg::COEF_W-1:0]  setpoint,        // staged setpoint
	input  logic signed [dsp_pkg::COEF_W-1:0]  p_coef,          // staged p
	input  logic signed [dsp_pkg::COEF_W-1:0]  i_coef,          // staged i
	input  logic signed [dsp_pkg::COEF_W-1:0]  d_coef,          // staged d
	input  logic                               lock_en,         // low holds everything at zero
	input  logic                               clear,           // zero history only
	input  logic                               update_en,       // arms the update pulse
	input  logic                               update,          // latch staged params
	output logic signed [dsp_pkg::W_OUT-1:0]   data_out,        // control value u
	output logic                               data_valid_out   // high in ST_SEND
);

	////////////////////////////////////////
	// internal state
	////////////////////////////////////////

	logic signed [dsp_pkg::W_OUT-1:0] data_q;                 // captured input
	logic signed [dsp_pkg::W_OUT-1:0] setpoint_q;             // active setpoint
	logic signed [dsp_pkg::W_OUT-1:0] p_q, i_q, d_q;          // active coefficients
	logic signed [dsp_pkg::W_OUT-1:0] e_cur, e1, e2;          // error now and history
	logic signed [dsp_pkg::W_OUT-1:0] k1, k2, k3;             // velocity form coefs
	logic signed [dsp_pkg::W_OUT-1:0] u_prev, u_cur;          // control value

	ctrl_pkg::pid_state_e state, state_next;
	logic [7:0] state_cnt;                                    // cycles spent in state

	////////////////////////////////////////
	// filter math
	////////////////////////////////////////

	assign e_cur = setpoint_q - data_q;
	assign k1    = p_q + i_q + d_q;
	assign k2    = -p_q - (d_q <<< 1);                       // -P - 2D
	assign k3    = d_q;
	assign u_cur = u_prev + k1 * e_cur + k2 * e1 + k3 * e2;  // wraps at 32 bits

	assign data_out       = u_cur;
	assign data_valid_out = (state == ctrl_pkg::ST_SEND);

	////////////////////////////////////////
	// data, params and history
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in || !lock_en) begin
			data_q <= '0;
		end else if (data_valid_in && state == ctrl_pkg::ST_IDLE) begin
			data_q <= data_in;  // sign extends to W_OUT
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in || !lock_en) begin
			setpoint_q <= '0;
			p_q        <= '0;
			i_q        <= '0;
			d_q        <= '0;
		end else if (update && update_en) begin
			setpoint_q <= setpoint;
			p_q        <= p_coef;
			i_q        <= i_coef;
			d_q        <= d_coef;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in || !lock_en || clear) begin
			u_prev <= '0;
			e1     <= '0;
			e2     <= '0;
		end else if (state == ctrl_pkg::ST_DONE) begin
			u_prev <= u_cur;  // shift once per pass
			e1     <= e_cur;
			e2     <= e1;
		end
	end

	////////////////////////////////////////
	// state machine
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state     <= ctrl_pkg::ST_IDLE;
			state_cnt <= '0;
		end else begin
			state <= state_next;
			if (state != state_next) begin
				state_cnt <= '0;                // fresh count per state
			end else if (state == ctrl_pkg::ST_COMPUTE) begin
				state_cnt <= state_cnt + 1'b1;
			end
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ctrl_pkg::ST_IDLE: begin
				if (data_valid_in) state_next = ctrl_pkg::ST_COMPUTE;
			end
			ctrl_pkg::ST_COMPUTE: begin
				if (state_cnt == 8'(dsp_pkg::COMP_LATENCY - 1)) state_next = ctrl_pkg::ST_SEND;
			end
			ctrl_pkg::ST_SEND: state_next = ctrl_pkg::ST_DONE;
			ctrl_pkg::ST_DONE: state_next = ctrl_pkg::ST_IDLE;
			default:           state_next = ctrl_pkg::ST_IDLE;
		endcase
	end

endmodule

/* src/pid_lock_top.sv */
`timescale 1ns/1ps

module pid_lock_top (
	input  logic                               clk_in,
	input  logic                               reset_in,
	input  logic signed [dsp_pkg::ADC_W-1:0]   adc_data,   // adc sample
	input  logic                               adc_valid,  // adc strobe
	input  logic                               wr_en,      // host write strobe
	input  ctrl_pkg::reg_addr_e                wr_addr,    // host opcode
	input  logic        [dsp_pkg::COEF_W-1:0]  wr_data,    // host payload
	output logic signed [dsp_pkg::DAC_W-1:0]   dac_data,   // dac word
	output logic                               dac_valid   // dac strobe
);

	////////////////////////////////////////
	// interconnect
	////////////////////////////////////////

	logic signed [dsp_pkg::W_IN-1:0]   sum_data;      // filter -> pid
	logic                              sum_valid;
	logic signed [dsp_pkg::COEF_W-1:0] setpoint;      // regs -> pid
	logic signed [dsp_pkg::COEF_W-1:0] p_coef;
	logic signed [dsp_pkg::COEF_W-1:0] i_coef;
	logic signed [dsp_pkg::COEF_W-1:0] d_coef;
	logic signed [dsp_pkg::COEF_W-1:0] manual_value;  // regs -> mux
	logic                              lock_en;
	logic                              update_en;
	logic                              update;
	logic                              clear;
	ctrl_pkg::source_e                 source;
	logic signed [dsp_pkg::W_OUT-1:0]  pid_data;      // pid -> mux
	logic                              pid_valid;

	////////////////////////////////////////
	// blocks
	////////////////////////////////////////

	oversample_filter filter_i (
		.clk_in    (clk_in),
		.reset_in  (reset_in),
		.adc_data  (adc_data),
		.adc_valid (adc_valid),
		.sum_data  (sum_data),
		.sum_valid (sum_valid)
	);

	frontpanel_regs regs_i (
		.clk_in       (clk_in),
		.reset_in     (reset_in),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.setpoint     (setpoint),
		.p_coef       (p_coef),
		.i_coef       (i_coef),
		.d_coef       (d_coef),
		.manual_value (manual_value),
		.lock_en      (lock_en),
		.update_en    (update_en),
		.update       (update),
		.clear        (clear),
		.source       (source)
	);

	pid_core pid_i (
		.clk_in         (clk_in),
		.reset_in       (reset_in),
		.data_in        (sum_data),
		.data_valid_in  (sum_valid),
		.setpoint       (setpoint),
		.p_coef         (p_coef),
		.i_coef         (i_coef),
		.d_coef         (d_coef),
		.lock_en        (lock_en),
		.clear          (clear),
		.update_en      (update_en),
		.update         (update),
		.data_out       (pid_data),
		.data_valid_out (pid_valid)
	);

	output_mux mux_i (
		.clk_in       (clk_in),
		.reset_in     (reset_in),
		.pid_data     (pid_data),
		.pid_valid    (pid_valid),
		.source       (source),
		.manual_value (manual_value),
		.dac_data     (dac_data),
		.dac_valid    (dac_valid)
	);

endmodule

/* tests/pid_lock_assertions.sv */
`timescale 1ns/1ps

module pid_lock_assertions (
	input logic clk_in,
	input logic reset_in,
	input logic strobe,       // upstream valid pulse
	input logic strobe_next,  // must follow the pulse by one cycle
	input logic busy          // block away from idle
);

	localparam int BUSY_CYCLES = dsp_pkg::COMP_LATENCY + 2;  // compute, send, done

	int unsigned fail_count = 0;  // failures seen by this instance

	strobe_single: assert property (@(posedge clk_in) disable iff (reset_in)
		strobe |=> !strobe)
		else begin
			$error("valid pulse held longer than one cycle");
			fail_count++;
		end

	strobe_follow: assert property (@(posedge clk_in) disable iff (reset_in)
		strobe |=> strobe_next)
		else begin
			$error("valid pulse not followed on the next cycle");
			fail_count++;
		end

	busy_length: assert property (@(posedge clk_in) disable iff (reset_in)
		$rose(busy) |-> busy [*BUSY_CYCLES] ##1 !busy)
		else begin
			$error("pid pass length differs from compute plus send plus done");
			fail_count++;
		end

endmodule

// core valid into the dac register and the core pass length
bind pid_lock_top pid_lock_assertions lock_chk (
	.clk_in      (clk_in),
	.reset_in    (reset_in),
	.strobe      (pid_valid),
	.strobe_next (dac_valid),
	.busy        (pid_i.state != ctrl_pkg::ST_IDLE)
);

/* tests/pid_lock_tb.sv */
`timescale 1ns/1ps

module pid_lock_tb;

	localparam int GROUP_COUNT = 36;                             // groups over all tests
	localparam int WATCHDOG_NS = (GROUP_COUNT * 12 + 2000) * 8;  // 8 ns clock

	logic                               clk_in = 1'b0;
	logic                               reset_in;
	logic signed [dsp_pkg::ADC_W-1:0]   adc_data;
	logic                               adc_valid;
	logic                               wr_en;
	ctrl_pkg::reg_addr_e                wr_addr;
	logic        [dsp_pkg::COEF_W-1:0]  wr_data;
	logic signed [dsp_pkg::DAC_W-1:0]   dac_data;
	logic                               dac_valid;

	// model of the staged and active registers
	logic signed [dsp_pkg::COEF_W-1:0] stage_sp = 0, stage_p = 0, stage_i = 0, stage_d = 0;
	logic signed [dsp_pkg::COEF_W-1:0] manual = 0;
	logic signed [dsp_pkg::W_OUT-1:0]  sp = 0, kp = 0, ki = 0, kd = 0;
	logic signed [dsp_pkg::W_OUT-1:0]  e1 = 0, e2 = 0, u_prev = 0;  // model history
	logic                              lock = 0, upd_en = 0, manual_sel = 0;

	logic [dsp_pkg::DAC_W-1:0] expected_q[$];  // expected dac words in order
	int errors = 0;
	int checks = 0;
	int tests_failed = 0;
	int dac_seen = 0;
	int seed = 32'h18a9c1b9;

	always #4 clk_in = ~clk_in;

	pid_lock_top dut_i (
		.clk_in    (clk_in),
		.reset_in  (reset_in),
		.adc_data  (adc_data),
		.adc_valid (adc_valid),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.dac_data  (dac_data),
		.dac_valid (dac_valid)
	);

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// one group in, expected dac word out, history moves on
	function automatic logic [dsp_pkg::DAC_W-1:0] model_group(input int sum);
		logic signed [dsp_pkg::W_OUT-1:0] k1, k2, e, u;
		k1 = kp + ki + kd;
		k2 = -kp - 2 * kd;
		e  = lock ? sp - sum : 0;                              // lock off holds all at zero
		u  = lock ? u_prev + k1 * e + k2 * e1 + kd * e2 : 0;  // wraps at 32 bits
		if (lock) begin
			e2     = e1;
			e1     = e;
			u_prev = u;
		end
		if (manual_sel) return manual;                         // pid still advanced
		if (u > 32767) return 16'h7fff;
		if (u < -32768) return 16'h8000;
		return u[dsp_pkg::DAC_W-1:0];
	endfunction

	////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////

	task automatic write_reg(input ctrl_pkg::reg_addr_e addr, input logic [15:0] data);
		@(posedge clk_in);
		wr_en   <= 1'b1;
		wr_addr <= addr;
		wr_data <= data;
		@(posedge clk_in);
		wr_en <= 1'b0;
		repeat (2) @(posedge clk_in);  // pulse reaches the core
		case (addr)
			ctrl_pkg::REG_SETPOINT: stage_sp = data;
			ctrl_pkg::REG_P_COEF:   stage_p = data;
			ctrl_pkg::REG_I_COEF:   stage_i = data;
			ctrl_pkg::REG_D_COEF:   stage_d = data;
			ctrl_pkg::REG_MANUAL:   manual = data;
			ctrl_pkg::REG_CONTROL: begin
				lock       = data[ctrl_pkg::CTRL_LOCK_BIT];
				upd_en     = data[ctrl_pkg::CTRL_UPDATE_EN_BIT];
				manual_sel = data[ctrl_pkg::CTRL_SOURCE_BIT];
				if (!lock) {sp, kp, ki, kd, e1, e2, u_prev} = '0;
			end
			ctrl_pkg::CMD_UPDATE: begin
				if (lock && upd_en) begin
					sp = stage_sp;  // sign extends
					kp = stage_p;
					ki = stage_i;
					kd = stage_d;
				end
			end
			ctrl_pkg::CMD_CLEAR: {e1, e2, u_prev} = '0;  // history only
			default: ;
		endcase
	endtask

	// four samples two cycles apart, then wait for the dac word
	task automatic feed_group(input logic signed [15:0] s0, s1, s2, s3);
		logic signed [15:0] smp[4];
		int sum;
		int target;
		int waited;
		smp    = '{s0, s1, s2, s3};
		sum    = 0;
		target = dac_seen + 1;
		waited = 0;
		foreach (smp[k]) sum += smp[k];
		expected_q.push_back(model_group(sum));
		foreach (smp[k]) begin
			@(posedge clk_in);
			adc_data  <= smp[k];
			adc_valid <= 1'b1;
			@(posedge clk_in);
			adc_valid <= 1'b0;
		end
		while (dac_seen < target && waited < 20) begin
			@(posedge clk_in);
			waited++;
		end
		if (dac_seen < target) begin
			$display("Error: no dac_valid arrived after a sample group");
			errors++;
		end
		repeat (2) @(posedge clk_in);  // core back in idle
	endtask

	task automatic feed_random_group(input int span);
		feed_group($random(seed) % span, $random(seed) % span, $random(seed) % span,
			$random(seed) % span);
	endtask

	////////////////////////////////////////
	// checking and report
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("Mismatch %s expected %h got %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - errors_before);
			tests_failed++;
		end
	endtask

	always @(negedge clk_in) begin  // dac word is stable mid cycle
		if (dac_valid) begin
			dac_seen++;
			if (expected_q.size() == 0) begin
				$display("Error: dac_valid with no expected value queued");
				errors++;
			end else begin
				check_value("dac_data", expected_q.pop_front(), dac_data);
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Error: timeout, the tests did not finish in time");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		int mark;
		reset_in  = 1'b1;
		adc_data  = '0;
		adc_valid = 1'b0;
		wr_en     = 1'b0;
		wr_addr   = ctrl_pkg::REG_SETPOINT;
		wr_data   = '0;
		repeat (16) @(posedge clk_in);
		reset_in <= 1'b0;

		mark = errors;  // lock off gives zero after reset
		repeat (20) @(posedge clk_in);
		if (dac_seen != 0) begin
			$display("Error: dac_valid went high before any sample");
			errors++;
		end
		repeat (3) feed_random_group(32768);
		report_test("reset and lock off", mark);

		mark = errors;  // u follows P*e with only p set
		write_reg(ctrl_pkg::REG_SETPOINT, 16'h0100);
		write_reg(ctrl_pkg::REG_P_COEF, 16'd3);
		write_reg(ctrl_pkg::REG_CONTROL, 16'h0003);
		write_reg(ctrl_pkg::CMD_UPDATE, 16'h0);
		repeat (8) feed_random_group(2048);
		report_test("proportional step", mark);

		mark = errors;  // integral ramp on a constant input
		write_reg(ctrl_pkg::REG_I_COEF, 16'd2);
		write_reg(ctrl_pkg::REG_D_COEF, 16'd5);
		write_reg(ctrl_pkg::CMD_UPDATE, 16'h0);
		write_reg(ctrl_pkg::CMD_CLEAR, 16'h0);
		repeat (6) feed_group(16'sd10, 16'sd10, 16'sd10, 16'sd10);
		report_test("integral and derivative history", mark);

		mark = errors;
		write_reg(ctrl_pkg::REG_P_COEF, 16'd100);      // staged only
		write_reg(ctrl_pkg::REG_SETPOINT, 16'h2000);
		repeat (3) feed_random_group(2048);
		write_reg(ctrl_pkg::REG_CONTROL, 16'h0001);    // update_en low
		write_reg(ctrl_pkg::CMD_UPDATE, 16'h0);
		repeat (3) feed_random_group(2048);
		write_reg(ctrl_pkg::REG_CONTROL, 16'h0003);
		write_reg(ctrl_pkg::CMD_CLEAR, 16'h0);
		repeat (3) feed_random_group(2048);
		report_test("update gating and clear", mark);

		mark = errors;
		write_reg(ctrl_pkg::REG_SETPOINT, 16'h0000);
		write_reg(ctrl_pkg::REG_P_COEF, 16'd1000);
		write_reg(ctrl_pkg::REG_I_COEF, 16'd0);
		write_reg(ctrl_pkg::REG_D_COEF, 16'd0);
		write_reg(ctrl_pkg::CMD_UPDATE, 16'h0);
		write_reg(ctrl_pkg::CMD_CLEAR, 16'h0);
		repeat (2) feed_group(-16'sd8000, -16'sd8000, -16'sd8000, -16'sd8000);  // 7fff
		repeat (2) feed_group(16'sd8000, 16'sd8000, 16'sd8000, 16'sd8000);      // 8000
		write_reg(ctrl_pkg::REG_I_COEF, 16'd100);      // integral sum lives in u_prev
		write_reg(ctrl_pkg::CMD_UPDATE, 16'h0);
		write_reg(ctrl_pkg::CMD_CLEAR, 16'h0);
		write_reg(ctrl_pkg::REG_MANUAL, 16'h1234);
		write_reg(ctrl_pkg::REG_CONTROL, 16'h0007);    // manual source
		repeat (3) feed_group(16'sd3, 16'sd3, 16'sd3, 16'sd3);  // steady error under manual
		write_reg(ctrl_pkg::REG_CONTROL, 16'h0003);    // back to pid
		repeat (3) feed_random_group(8);
		report_test("saturation and manual source", mark);

		if (expected_q.size() != 0) begin
			$display("Error: %0d expected dac words never arrived", expected_q.size());
			errors++;
		end
		errors += dut_i.lock_chk.fail_count;
		$display("tests 5 run, %0d failed, %0d checks, %0d errors", tests_failed, checks,
			errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* verilog.f */
src/dsp_pkg.sv
src/ctrl_pkg.sv
src/oversample_filter.sv
src/frontpanel_regs.sv
src/pid_core.sv
src/output_mux.sv
src/pid_lock_top.sv
tests/pid_lock_assertions.sv
tests/pid_lock_tb.sv
